//--- rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // major opcodes of the supported instruction groups
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;

    localparam logic [2:0] F3_ADD  = 3'b000;  // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL and SRA share funct3
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } aluOpT;

    typedef enum logic [1:0] {
        OPB_REG   = 2'b00,
        OPB_IMM   = 2'b01,
        OPB_SHAMT = 2'b10
    } opBSelT;

    // alt is instr[30], already masked off where it is part of an immediate
    function automatic aluOpT aluFromFunct3(input logic [2:0] funct3, input logic alt);
        case (funct3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rvPipePkg.sv
`default_nettype none

package rvPipePkg;

    // decoder to issue stage
    typedef struct packed {
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        rvIsaPkg::aluOpT  aluOp;
        rvIsaPkg::opBSelT opBSel;
        logic [31:0]     imm;      // sign extended I-imm, or U-imm for LUI
        logic [4:0]      shamt;
        logic            usesRs2;  // only R-type reads rs2
    } decodedOpT;

    // issue stage to execute, operands already resolved
    typedef struct packed {
        logic [31:0]     opA;
        logic [31:0]     opB;
        rvIsaPkg::aluOpT aluOp;
        logic [4:0]      rd;
    } issuedOpT;

endpackage

`default_nettype wire

//--- decodeLink.sv
`timescale 1ns/1ps
`default_nettype none

// credit based link, one credit per free issue queue entry
interface decodeLink;
    import rvPipePkg::*;

    logic      opValid;
    decodedOpT op;
    logic      credit;   // one pulse per entry leaving the issue queue

    modport sender (output opValid, output op, input credit);
    modport receiver (input opValid, input op, output credit);

endinterface

`default_nettype wire

//--- issueLink.sv
`timescale 1ns/1ps
`default_nettype none

// credit based link toward the execute input queue
interface issueLink;
    import rvPipePkg::*;

    logic     opValid;
    issuedOpT op;
    logic     credit;   // pulsed by execute on every pop

    modport sender (output opValid, output op, input credit);
    modport receiver (input opValid, input op, output credit);

endinterface

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        instrValid,
    input  logic [31:0] instr,
    output logic        instrReady,
    decodeLink.sender   link
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       altBit;
    logic       supported;
    decodedOpT  dec;

    logic       full;      // output register holds an op
    decodedOpT  opReg;
    logic [CW-1:0] credits;
    logic       accept;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    // bit 30 is immediate data for every OP-IMM except the right shifts
    assign altBit = instr[30] && (opcode == OPC_OP || funct3 == F3_SR);

    always_comb
    begin
        dec         = '0;
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.rd      = instr[11:7];
        dec.shamt   = instr[24:20];
        dec.imm     = {{20{instr[31]}}, instr[31:20]};
        dec.aluOp   = aluFromFunct3(funct3, altBit);
        dec.opBSel  = OPB_IMM;
        dec.usesRs2 = 1'b0;
        supported   = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                dec.opBSel  = OPB_REG;
                dec.usesRs2 = 1'b1;
                supported   = (funct7 == F7_BASE) ||
                              (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
            end
            OPC_OPIMM:
            begin
                if (funct3 == F3_SLL || funct3 == F3_SR)
                begin
                    dec.opBSel = OPB_SHAMT;
                    supported  = (funct7 == F7_BASE) || (funct7 == F7_ALT && funct3 == F3_SR);
                end
                else
                    supported = 1'b1;
            end
            OPC_LUI:
            begin
                dec.rs1   = '0;                 // becomes ADDI rd, x0, U-imm
                dec.aluOp = ALU_ADD;
                dec.imm   = {instr[31:12], 12'b0};
                supported = 1'b1;
            end
            default: supported = 1'b0;        // dropped at acceptance
        endcase
    end

    assign link.opValid = full && (credits != '0);
    assign link.op      = opReg;
    assign instrReady   = !full || link.opValid;
    assign accept       = instrValid && instrReady;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            full    <= 1'b0;
            credits <= CW'(QUEUE_DEPTH);
        end
        else
        begin
            if (accept)
                full <= supported;
            else if (link.opValid)
                full <= 1'b0;
            credits <= credits - CW'(link.opValid) + CW'(link.credit);
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            opReg <= dec;
    end

    assert property (@(posedge clk) disable iff (!nrst) credits <= QUEUE_DEPTH)
        else $error("decoder holds more credits than issue queue entries");

    // a credit only comes back for an op that was sent
    assert property (@(posedge clk) disable iff (!nrst) link.credit |-> credits < CW'(QUEUE_DEPTH))
        else $error("decoder got a credit back with none outstanding");

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        nrst,
    input  logic        we,
    input  logic [4:0]  writeAddr,
    input  logic [4:0]  srcA,
    input  logic [4:0]  srcB,
    input  logic [31:0] writeData,
    output logic [31:0] dataA,
    output logic [31:0] dataB
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && writeAddr != 5'd0)   // x0 stays zero
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // no write-through, the issue stage waits out a same cycle writeback
    assign dataA = regs[srcA];
    assign dataB = regs[srcB];

endmodule

`default_nettype wire

//--- issueStage.sv
`timescale 1ns/1ps
`default_nettype none

module issueStage #(
    parameter int QUEUE_DEPTH = 4,
    parameter int EXEC_DEPTH  = 2
) (
    input  logic        clk,
    input  logic        nrst,
    decodeLink.receiver inLink,
    issueLink.sender    outLink,
    input  logic        wbValid,
    input  logic [4:0]  wbRd,
    input  logic [31:0] wbData
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);
    localparam int EW = $clog2(EXEC_DEPTH + 1);

    decodedOpT     queue [QUEUE_DEPTH];
    logic [PW-1:0] rdPtr, wrPtr;
    logic [CW-1:0] count;
    decodedOpT     head;

    logic [31:0]   busy;        // one bit per register with a result in flight
    logic [EW-1:0] execCredits;
    logic          rs1Hold, rs2Hold, rdHold;
    logic          issueFire;

    logic [31:0]   dataA, dataB;
    logic [31:0]   opB;
    logic          issueValid;
    issuedOpT      issueReg;

    assign head = queue[rdPtr];

    // a result on its way back is written at the coming edge, not before
    assign rs1Hold = busy[head.rs1] || (wbValid && wbRd == head.rs1);
    assign rs2Hold = head.usesRs2 && (busy[head.rs2] || (wbValid && wbRd == head.rs2));
    assign rdHold  = busy[head.rd];   // keeps a later writer from clearing busy too early

    assign issueFire = (count != '0) && (execCredits != '0) && !rs1Hold && !rs2Hold && !rdHold;

    assign inLink.credit = issueFire;

    regFile regFile_i (
        .clk       (clk),
        .nrst      (nrst),
        .we        (wbValid),
        .writeAddr (wbRd),
        .srcA      (head.rs1),
        .srcB      (head.rs2),
        .writeData (wbData),
        .dataA     (dataA),
        .dataB     (dataB)
    );

    always_comb
    begin
        case (head.opBSel)
            OPB_IMM:   opB = head.imm;
            OPB_SHAMT: opB = {27'b0, head.shamt};
            default:   opB = dataB;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rdPtr       <= '0;
            wrPtr       <= '0;
            count       <= '0;
            busy        <= '0;
            execCredits <= EW'(EXEC_DEPTH);
            issueValid  <= 1'b0;
        end
        else
        begin
            if (inLink.opValid)
                wrPtr <= (wrPtr == PW'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (issueFire)
                rdPtr <= (rdPtr == PW'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            count <= count + CW'(inLink.opValid) - CW'(issueFire);
            // clear on writeback, set on issue, x0 never busy
            busy <= (busy & ~(wbValid ? (32'b1 << wbRd) : 32'b0)) |
                    ((issueFire && head.rd != 5'd0) ? (32'b1 << head.rd) : 32'b0);
            execCredits <= execCredits - EW'(issueFire) + EW'(outLink.credit);
            issueValid  <= issueFire;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inLink.opValid)
            queue[wrPtr] <= inLink.op;
        if (issueFire)
        begin
            issueReg.opA   <= dataA;
            issueReg.opB   <= opB;
            issueReg.aluOp <= head.aluOp;
            issueReg.rd    <= head.rd;
        end
    end

    assign outLink.opValid = issueValid;
    assign outLink.op      = issueReg;

    assert property (@(posedge clk) disable iff (!nrst) inLink.opValid |-> count < QUEUE_DEPTH)
        else $error("issue queue overflow");

    // a credit can only come back for an op that was issued
    assert property (@(posedge clk) disable iff (!nrst) outLink.credit |-> execCredits < EXEC_DEPTH)
        else $error("execute returned a credit that was never spent");

endmodule

`default_nettype wire

//--- aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute #(
    parameter int EXEC_DEPTH = 2
) (
    input  logic        clk,
    input  logic        nrst,
    issueLink.receiver  inLink,
    output logic        wbValid,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData,
    output logic        resultValid,
    output logic [4:0]  resultRd,
    output logic [31:0] resultData
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    localparam int PW = (EXEC_DEPTH > 1) ? $clog2(EXEC_DEPTH) : 1;
    localparam int CW = $clog2(EXEC_DEPTH + 1);

    issuedOpT      queue [EXEC_DEPTH];
    logic [PW-1:0] rdPtr, wrPtr;
    logic [CW-1:0] count;
    issuedOpT      head;
    logic          pop;
    logic [31:0]   aluOut;

    logic          resValid;
    logic [4:0]    resRd;
    logic [31:0]   resData;

    assign head          = queue[rdPtr];
    assign pop           = count != '0;   // one op per cycle whenever something is queued
    assign inLink.credit = pop;

    always_comb
    begin
        case (head.aluOp)
            ALU_ADD:  aluOut = head.opA + head.opB;
            ALU_SUB:  aluOut = head.opA - head.opB;
            ALU_SLL:  aluOut = head.opA << head.opB[4:0];
            ALU_SLT:  aluOut = {31'b0, $signed(head.opA) < $signed(head.opB)};
            ALU_SLTU: aluOut = {31'b0, head.opA < head.opB};
            ALU_XOR:  aluOut = head.opA ^ head.opB;
            ALU_SRL:  aluOut = head.opA >> head.opB[4:0];
            ALU_SRA:  aluOut = $signed(head.opA) >>> head.opB[4:0];
            ALU_OR:   aluOut = head.opA | head.opB;
            default:  aluOut = head.opA & head.opB;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rdPtr    <= '0;
            wrPtr    <= '0;
            count    <= '0;
            resValid <= 1'b0;
        end
        else
        begin
            if (inLink.opValid)
                wrPtr <= (wrPtr == PW'(EXEC_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == PW'(EXEC_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            count    <= count + CW'(inLink.opValid) - CW'(pop);
            resValid <= pop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inLink.opValid)
            queue[wrPtr] <= inLink.op;
        if (pop)
        begin
            resRd   <= head.rd;
            resData <= aluOut;
        end
    end

    // writeback and the result port share one register set
    assign wbValid     = resValid;
    assign wbRd        = resRd;
    assign wbData      = resData;
    assign resultValid = resValid;
    assign resultRd    = resRd;
    assign resultData  = resData;

    // the op in the issue register already holds a credit, so the queue has room for it
    assert property (@(posedge clk) disable iff (!nrst) inLink.opValid |-> count < EXEC_DEPTH)
        else $error("execute queue overflow");

endmodule

`default_nettype wire

//--- rvIssueTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvIssueTop #(
    parameter int QUEUE_DEPTH = 4,
    parameter int EXEC_DEPTH  = 2
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        instrValid,
    input  logic [31:0] instr,
    output logic        instrReady,
    output logic        resultValid,
    output logic [4:0]  resultRd,
    output logic [31:0] resultData
);

    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    decodeLink decLink ();
    issueLink  issLink ();

    instrDecoder #(.QUEUE_DEPTH(QUEUE_DEPTH)) instrDecoder_i (
        .clk        (clk),
        .nrst       (nrst),
        .instrValid (instrValid),
        .instr      (instr),
        .instrReady (instrReady),
        .link       (decLink.sender)
    );

    issueStage #(.QUEUE_DEPTH(QUEUE_DEPTH), .EXEC_DEPTH(EXEC_DEPTH)) issueStage_i (
        .clk     (clk),
        .nrst    (nrst),
        .inLink  (decLink.receiver),
        .outLink (issLink.sender),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

    aluExecute #(.EXEC_DEPTH(EXEC_DEPTH)) aluExecute_i (
        .clk         (clk),
        .nrst        (nrst),
        .inLink      (issLink.receiver),
        .wbValid     (wbValid),
        .wbRd        (wbRd),
        .wbData      (wbData),
        .resultValid (resultValid),
        .resultRd    (resultRd),
        .resultData  (resultData)
    );

endmodule

`default_nettype wire

//--- rvIssueTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvIssueTb;
    import rvIsaPkg::*;

    localparam int MAX_CYCLES = 4000;   // well above the combined length of all tests

    logic        clk = 1'b0;
    logic        nrst;
    logic        instrValid;
    logic [31:0] instr;
    logic        instrReady;
    logic        resultValid;
    logic [4:0]  resultRd;
    logic [31:0] resultData;

    logic [31:0] regs [32];         // software register model
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    logic [4:0]  wantRd;
    logic [31:0] wantData;
    string       testName = "reset";
    int          seed = 32'hafd4;
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          resultCount = 0;
    int          supportedSent = 0;
    int          cycleCount = 0;
    logic        sawNotReady;

    rvIssueTop rvIssueTop_i (
        .clk         (clk),
        .nrst        (nrst),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrReady  (instrReady),
        .resultValid (resultValid),
        .resultRd    (resultRd),
        .resultData  (resultData)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles in test %s", cycleCount, testName);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // results are registered, so the falling edge sees them settled
    always @(negedge clk)
    begin
        if (nrst && resultValid)
        begin
            resultCount++;
            if (expRd.size() == 0)
            begin
                $display("unexpected result for x%0d in test %s", resultRd, testName);
                otherErrors++;
            end
            else
            begin
                wantRd   = expRd.pop_front();
                wantData = expData.pop_front();
                assert (resultRd == wantRd)
                else
                begin
                    $display("Error: %s rd expected %0d actual %0d", testName, wantRd, resultRd);
                    valueErrors++;
                end
                assert (resultData == wantData)
                else
                begin
                    $display("Error: %s data expected %h actual %h", testName, wantData,
                             resultData);
                    valueErrors++;
                end
            end
        end
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] encI(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OPIMM};
    endfunction

    function automatic logic [31:0] encLui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    // reference ALU straight from the RV32I funct3 table
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic stepModel(input logic [31:0] word);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] res;
        logic        ok;
        f3  = word[14:12];
        f7  = word[31:25];
        res = '0;
        ok  = 1'b1;
        if (word[6:0] == OPC_OP)
        begin
            ok  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            res = refAlu(f3, f7[5], regs[word[19:15]], regs[word[24:20]]);
        end
        else if (word[6:0] == OPC_OPIMM)
        begin
            if (f3 == 3'd1)
                ok = (f7 == 7'h00);
            else if (f3 == 3'd5)
                ok = (f7 == 7'h00) || (f7 == 7'h20);
            res = refAlu(f3, f3 == 3'd5 && f7[5], regs[word[19:15]],
                         {{20{word[31]}}, word[31:20]});
        end
        else if (word[6:0] == OPC_LUI)
            res = {word[31:12], 12'b0};
        else
            ok = 1'b0;   // other opcodes give no result
        if (ok)
        begin
            if (word[11:7] != 5'd0)
                regs[word[11:7]] = res;
            expRd.push_back(word[11:7]);
            expData.push_back(res);
            supportedSent++;
        end
    endtask

    // entered on a falling edge, returns on the falling edge after acceptance
    task automatic sendInstr(input logic [31:0] word);
        instr      = word;
        instrValid = 1'b1;
        while (!instrReady)
        begin
            sawNotReady = 1'b1;
            @(negedge clk);
        end
        stepModel(word);
        @(negedge clk);
    endtask

    task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;   // addi sign-extends the low part
        sendInstr(encLui(rd, upper[31:12]));
        sendInstr(encI(F3_ADD, rd, rd, value[11:0]));
    endtask

    task automatic waitDrain;
        instrValid = 1'b0;
        while (expRd.size() != 0)
            @(negedge clk);
        repeat (8) @(negedge clk);   // quiet window, a stray result would show here
    endtask

    task automatic testImmediates;
        testName = "immediates";
        sendInstr(encLui(5'd1, 20'h12345));
        sendInstr(encI(F3_ADD, 5'd2, 5'd1, 12'h678));
        sendInstr(encI(F3_OR, 5'd3, 5'd2, 12'hf00));
        sendInstr(encI(F3_XOR, 5'd4, 5'd3, 12'h0ff));
        sendInstr(encI(F3_AND, 5'd5, 5'd4, 12'h7f0));
        sendInstr(encI(F3_SLT, 5'd6, 5'd5, 12'hfff));
        sendInstr(encI(F3_SLTU, 5'd7, 5'd5, 12'hfff));
        sendInstr(encLui(5'd8, 20'hfffff));
        sendInstr(encI(F3_SLT, 5'd9, 5'd8, 12'h001));
        sendInstr(encI(F3_SLTU, 5'd10, 5'd8, 12'h001));
        sendInstr(encI(F3_ADD, 5'd0, 5'd1, 12'h055));   // write to x0 is dropped
        sendInstr(encI(F3_ADD, 5'd11, 5'd0, 12'h007));
        sendInstr(encI(F3_OR, 5'd12, 5'd0, 12'h800));
        waitDrain();
    endtask

    task automatic testRType;
        logic [31:0] v;
        testName = "rtype";
        for (int round = 0; round < 4; round++)
        begin
            for (int r = 1; r <= 4; r++)
            begin
                v = $random(seed);
                if (r == 1)
                    v[31] = 1'b1;   // signed and unsigned compares disagree
                if (r == 2)
                    v[31] = 1'b0;
                loadReg(5'(r), v);
            end
            sendInstr(encR(F7_BASE, F3_ADD, 5'd5, 5'd1, 5'd2));
            sendInstr(encR(F7_ALT, F3_ADD, 5'd6, 5'd1, 5'd2));
            sendInstr(encR(F7_BASE, F3_AND, 5'd7, 5'd3, 5'd4));
            sendInstr(encR(F7_BASE, F3_OR, 5'd8, 5'd3, 5'd4));
            sendInstr(encR(F7_BASE, F3_XOR, 5'd9, 5'd3, 5'd4));
            sendInstr(encR(F7_BASE, F3_SLT, 5'd10, 5'd1, 5'd2));
            sendInstr(encR(F7_BASE, F3_SLTU, 5'd11, 5'd1, 5'd2));
            sendInstr(encR(F7_BASE, F3_SLL, 5'd12, 5'd3, 5'd4));
            sendInstr(encR(F7_BASE, F3_SR, 5'd13, 5'd1, 5'd4));
            sendInstr(encR(F7_ALT, F3_SR, 5'd14, 5'd1, 5'd2));
            v = $random(seed);
            sendInstr(encI(F3_SLL, 5'd15, 5'd1, {7'h00, v[4:0]}));
            sendInstr(encI(F3_SR, 5'd16, 5'd1, {7'h00, v[9:5]}));
            sendInstr(encI(F3_SR, 5'd17, 5'd1, {7'h20, v[14:10]}));
        end
        waitDrain();
    endtask

    task automatic testDependencies;
        testName = "dependencies";
        sendInstr(encI(F3_ADD, 5'd20, 5'd0, 12'h123));
        for (int i = 0; i < 8; i++)
        begin
            sendInstr(encR(F7_BASE, F3_ADD, 5'd21, 5'd20, 5'd20));
            sendInstr(encI(F3_XOR, 5'd20, 5'd21, 12'h5a5));
            sendInstr(encR(F7_ALT, F3_ADD, 5'd22, 5'd20, 5'd21));
            sendInstr(encI(F3_SR, 5'd20, 5'd22, {7'h20, 5'd3}));
        end
        waitDrain();
    endtask

    task automatic testUnsupported;
        testName = "unsupported";
        sendInstr(encI(F3_ADD, 5'd23, 5'd0, 12'd100));
        sendInstr(32'h00b50463);                          // beq x10, x11, 8
        sendInstr(encI(F3_ADD, 5'd23, 5'd23, 12'd1));
        sendInstr(32'h0000ab83);                          // lw x23, 0(x1)
        sendInstr(encR(7'h01, F3_ADD, 5'd23, 5'd23, 5'd23));  // mul
        sendInstr(encR(F7_BASE, F3_ADD, 5'd24, 5'd23, 5'd23));
        sendInstr(32'h0000000f);                          // fence
        sendInstr(encI(F3_OR, 5'd25, 5'd24, 12'h800));
        waitDrain();
    endtask

    task automatic testBackPressure;
        int startResults;
        int startSent;
        testName     = "backpressure";
        startResults = resultCount;
        startSent    = supportedSent;
        sawNotReady  = 1'b0;
        for (int i = 0; i < 24; i++)
        begin
            if (i % 3 == 2)
                sendInstr(encR(F7_BASE, F3_XOR, 5'd26, 5'd26, 5'd25));
            else
                sendInstr(encI(F3_ADD, 5'd26, 5'd26, 12'(i + 1)));
        end
        waitDrain();
        assert (resultCount - startResults == supportedSent - startSent)
        else
        begin
            $display("Error: %s result count expected %0d actual %0d", testName,
                     supportedSent - startSent, resultCount - startResults);
            valueErrors++;
        end
        assert (sawNotReady)
        else
        begin
            $display("instrReady never dropped during the dependent burst");
            otherErrors++;
        end
    endtask

    initial
    begin
        nrst       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        assert (instrReady)
        else
        begin
            $display("instrReady low after reset");
            otherErrors++;
        end
        testImmediates();
        testRType();
        testDependencies();
        testUnsupported();
        testBackPressure();
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rvIsaPkg.sv
rvPipePkg.sv
decodeLink.sv
issueLink.sv
instrDecoder.sv
regFile.sv
issueStage.sv
aluExecute.sv
rvIssueTop.sv
rvIssueTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the testbench with Verilator, the log decides the outcome

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module rvIssueTb -f flist.f -o rvIssueTbSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rvIssueTbSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
exit 1
